// ==== hw/ooo_pkg.sv ====
`default_nettype none

package ooo_pkg;

    localparam int XLEN      = 32;
    localparam int ROB_DEPTH = 8;
    localparam int TAG_W     = 3;

    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

    typedef logic [XLEN-1:0]  xlen_t;
    typedef logic [4:0]       arch_reg_t;
    typedef logic [TAG_W-1:0] rob_tag_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    // order follows funct3[1:0]
    typedef enum logic [1:0] {MUL_MUL, MUL_MULH, MUL_MULHSU, MUL_MULHU} mul_op_e;

    typedef enum logic [1:0] {FU_ALU, FU_MUL, FU_NONE} fu_sel_e;

    typedef struct packed {
        logic [6:0] funct7;
        arch_reg_t  rs2;
        arch_reg_t  rs1;
        logic [2:0] funct3;
        arch_reg_t  rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm12;
        arch_reg_t   rs1;
        logic [2:0]  funct3;
        arch_reg_t   rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
    } inst_word_u;

    typedef struct packed {
        logic     ready;
        rob_tag_t tag;
        xlen_t    value;
    } operand_t;

    typedef struct packed {
        fu_sel_e    fu;
        logic [3:0] op;     // alu_op_e or mul_op_e, per unit
        arch_reg_t  rd;
        logic       wr_en;
        arch_reg_t  rs1;
        arch_reg_t  rs2;
        logic       use_imm;
        xlen_t      imm;
    } uop_t;

    typedef struct packed {
        logic [3:0] op;
        operand_t   src1;
        operand_t   src2;
        rob_tag_t   dest;
    } rs_entry_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        xlen_t    value;
    } cdb_t;

    typedef struct packed {
        logic      wr_en;
        arch_reg_t rd;
        xlen_t     value;
    } commit_t;

endpackage

`default_nettype wire

// ==== hw/issue_decoder.sv ====
`default_nettype none
`timescale 1ns/1ps

module issue_decoder
    import ooo_pkg::*;
(
    input  logic  inst_valid,
    input  xlen_t inst,
    input  logic  rob_full,
    input  logic  alu_rs_full,
    input  logic  mul_rs_full,
    output logic  issue_ready,
    output logic  dispatch,
    output uop_t  uop
);

    inst_word_u iw;
    logic       unit_free;
    logic       is_shift;

    function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  alu_decode = alt ? ALU_SUB : ALU_ADD;
            3'b001:  alu_decode = ALU_SLL;
            3'b010:  alu_decode = ALU_SLT;
            3'b011:  alu_decode = ALU_SLTU;
            3'b100:  alu_decode = ALU_XOR;
            3'b101:  alu_decode = alt ? ALU_SRA : ALU_SRL;
            3'b110:  alu_decode = ALU_OR;
            default: alu_decode = ALU_AND;
        endcase
    endfunction

    assign iw       = inst;
    assign is_shift = (iw.i.funct3 == 3'b001) || (iw.i.funct3 == 3'b101);

    always_comb begin
        uop     = '0;
        uop.fu  = FU_NONE;
        uop.rd  = iw.r.rd;
        uop.rs1 = iw.r.rs1;
        uop.rs2 = iw.r.rs2;
        case (iw.r.opcode)
            OPC_OP: begin
                if (iw.r.funct7 == FUNCT7_MULDIV) begin
                    if (!iw.r.funct3[2]) begin  // div/rem not supported
                        uop.fu = FU_MUL;
                        uop.op = {2'b00, iw.r.funct3[1:0]};
                    end
                end else begin
                    uop.fu = FU_ALU;
                    uop.op = alu_decode(iw.r.funct3, iw.r.funct7[5]);
                end
            end
            OPC_OP_IMM: begin
                uop.fu      = FU_ALU;
                uop.use_imm = 1'b1;
                uop.op      = alu_decode(iw.i.funct3, iw.i.imm12[10] && iw.i.funct3 == 3'b101);
                uop.imm     = is_shift ? {27'b0, iw.i.imm12[4:0]}
                                       : {{20{iw.i.imm12[11]}}, iw.i.imm12};
            end
            default: ;
        endcase
        uop.wr_en = (uop.fu != FU_NONE) && (iw.r.rd != '0);
    end

    always_comb begin
        case (uop.fu)
            FU_ALU:  unit_free = !alu_rs_full;
            FU_MUL:  unit_free = !mul_rs_full;
            default: unit_free = 1'b1;
        endcase
    end

    assign issue_ready = !rob_full && unit_free;
    assign dispatch    = inst_valid && issue_ready;

endmodule

`default_nettype wire

// ==== hw/rename_table.sv ====
`default_nettype none
`timescale 1ns/1ps

module rename_table
    import ooo_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      dispatch,
    input  uop_t      uop,
    input  rob_tag_t  alloc_tag,
    input  logic      rob_done1,
    input  logic      rob_done2,
    input  xlen_t     rob_value1,
    input  xlen_t     rob_value2,
    input  cdb_t      cdb,
    input  logic      commit_valid,
    input  commit_t   commit,
    input  rob_tag_t  commit_tag,
    output rob_tag_t  query_tag1,
    output rob_tag_t  query_tag2,
    output rs_entry_t entry
);

    xlen_t       regs [32];
    rob_tag_t    map  [32];
    logic [31:0] busy;

    function automatic operand_t resolve(input arch_reg_t r, input logic done,
                                         input xlen_t done_val);
        operand_t o;
        o.ready = 1'b1;
        o.tag   = map[r];
        if (!busy[r]) begin
            o.value = (r == '0) ? '0 : regs[r];
        end else if (done) begin
            o.value = done_val;
        end else if (cdb.valid && cdb.tag == map[r]) begin
            o.value = cdb.value;    // result arriving this cycle
        end else begin
            o.ready = 1'b0;
            o.value = '0;
        end
        return o;
    endfunction

    assign query_tag1 = map[uop.rs1];
    assign query_tag2 = map[uop.rs2];

    always_comb begin
        entry.op   = uop.op;
        entry.src1 = resolve(uop.rs1, rob_done1, rob_value1);
        if (uop.use_imm)
            entry.src2 = '{ready: 1'b1, tag: '0, value: uop.imm};
        else
            entry.src2 = resolve(uop.rs2, rob_done2, rob_value2);
        entry.dest = alloc_tag;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else begin
            if (commit_valid && commit.wr_en && commit.rd != '0) begin
                regs[commit.rd] <= commit.value;
                if (map[commit.rd] == commit_tag)
                    busy[commit.rd] <= 1'b0;
            end
            // a new producer overrides the clear above
            if (dispatch && uop.wr_en)
                busy[uop.rd] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch && uop.wr_en)
            map[uop.rd] <= alloc_tag;
    end

endmodule

`default_nettype wire

// ==== hw/reservation_station.sv ====
`default_nettype none
`timescale 1ns/1ps

module reservation_station
    import ooo_pkg::*;
#(
    parameter int DEPTH = 4
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      load,
    input  rs_entry_t entry,
    input  cdb_t      cdb,
    input  logic      unit_ready,
    output logic      full,
    output logic      send,
    output rs_entry_t req
);

    localparam int SEL_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    // slot 0 is always the oldest, entries are kept compacted
    rs_entry_t        slots      [DEPTH];
    rs_entry_t        woken      [DEPTH];
    rs_entry_t        next_slots [DEPTH];
    logic [DEPTH-1:0] valid;
    logic [DEPTH-1:0] next_valid;
    logic [DEPTH-1:0] rdy;
    logic [SEL_W-1:0] sel;
    logic             found;

    function automatic operand_t wake(input operand_t o, input cdb_t b);
        operand_t w;
        w = o;
        if (!o.ready && b.valid && b.tag == o.tag) begin
            w.ready = 1'b1;
            w.value = b.value;
        end
        return w;
    endfunction

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            woken[i]      = slots[i];
            woken[i].src1 = wake(slots[i].src1, cdb);
            woken[i].src2 = wake(slots[i].src2, cdb);
            rdy[i]        = valid[i] && slots[i].src1.ready && slots[i].src2.ready;
        end
    end

    // lowest ready index wins
    always_comb begin
        found = 1'b0;
        sel   = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (rdy[i]) begin
                found = 1'b1;
                sel   = SEL_W'(i);
            end
        end
    end

    assign send = found && unit_ready;
    assign req  = slots[sel];
    assign full = &valid;

    always_comb begin
        int n;
        n          = 0;
        next_slots = woken;
        next_valid = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (valid[i] && !(send && sel == SEL_W'(i))) begin
                next_slots[n] = woken[i];
                next_valid[n] = 1'b1;
                n++;
            end
        end
        if (load && n < DEPTH) begin
            next_slots[n] = entry;
            next_valid[n] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            valid <= '0;
        else
            valid <= next_valid;
    end

    always_ff @(posedge clk) begin
        slots <= next_slots;
    end

endmodule

`default_nettype wire

// ==== hw/alu_unit.sv ====
`default_nettype none
`timescale 1ns/1ps

module alu_unit
    import ooo_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      send,
    input  rs_entry_t req,
    input  logic      mul_busy,
    output logic      ready,
    output cdb_t      cdb_alu
);

    xlen_t    a;
    xlen_t    b;
    xlen_t    y;
    logic     res_valid;
    rob_tag_t res_tag;
    xlen_t    res_value;
    logic     hold;

    assign a = req.src1.value;
    assign b = req.src2.value;

    always_comb begin
        case (alu_op_e'(req.op))
            ALU_ADD:  y = a + b;
            ALU_SUB:  y = a - b;
            ALU_SLL:  y = a << b[4:0];
            ALU_SLT:  y = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: y = {31'b0, a < b};
            ALU_XOR:  y = a ^ b;
            ALU_SRL:  y = a >> b[4:0];
            ALU_SRA:  y = xlen_t'($signed(a) >>> b[4:0]);
            ALU_OR:   y = a | b;
            ALU_AND:  y = a & b;
            default:  y = '0;
        endcase
    end

    assign hold    = res_valid && mul_busy;  // lost the bus this cycle
    assign ready   = !hold;
    assign cdb_alu = '{valid: res_valid, tag: res_tag, value: res_value};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            res_valid <= 1'b0;
        else if (!hold)
            res_valid <= send;
    end

    always_ff @(posedge clk) begin
        if (!hold && send) begin
            res_tag   <= req.dest;
            res_value <= y;
        end
    end

endmodule

`default_nettype wire

// ==== hw/multiplier.sv ====
`default_nettype none
`timescale 1ns/1ps

module multiplier
    import ooo_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      send,
    input  rs_entry_t req,
    input  cdb_t      alu_result,
    output logic      mul_busy,
    output cdb_t      cdb
);

    mul_op_e            op_in;
    logic               a_signed;
    logic               b_signed;
    logic [2:0]         stage_valid;
    mul_op_e            s1_op;
    mul_op_e            s2_op;
    rob_tag_t           s1_tag;
    rob_tag_t           s2_tag;
    rob_tag_t           s3_tag;
    logic signed [32:0] s1_a;
    logic signed [32:0] s1_b;
    logic signed [65:0] full_prod;
    logic [63:0]        s2_prod;
    xlen_t              s3_value;

    assign op_in    = mul_op_e'(req.op[1:0]);
    assign a_signed = (op_in == MUL_MULH) || (op_in == MUL_MULHSU);
    assign b_signed = (op_in == MUL_MULH);

    assign full_prod = s1_a * s1_b;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            stage_valid <= '0;
        else
            stage_valid <= {stage_valid[1:0], send};
    end

    always_ff @(posedge clk) begin
        // 33-bit operands cover signed, unsigned and mixed forms
        s1_a     <= {a_signed & req.src1.value[XLEN-1], req.src1.value};
        s1_b     <= {b_signed & req.src2.value[XLEN-1], req.src2.value};
        s1_op    <= op_in;
        s1_tag   <= req.dest;
        s2_prod  <= full_prod[63:0];
        s2_op    <= s1_op;
        s2_tag   <= s1_tag;
        s3_value <= (s2_op == MUL_MUL) ? s2_prod[31:0] : s2_prod[63:32];
        s3_tag   <= s2_tag;
    end

    assign mul_busy = stage_valid[2];

    always_comb begin
        if (stage_valid[2])
            cdb = '{valid: 1'b1, tag: s3_tag, value: s3_value};
        else
            cdb = alu_result;
    end

endmodule

`default_nettype wire

// ==== hw/reorder_buffer.sv ====
`default_nettype none
`timescale 1ns/1ps

module reorder_buffer
    import ooo_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     dispatch,
    input  uop_t     uop,
    input  cdb_t     cdb,
    input  rob_tag_t query_tag1,
    input  rob_tag_t query_tag2,
    output logic     full,
    output rob_tag_t alloc_tag,
    output logic     rob_done1,
    output logic     rob_done2,
    output xlen_t    rob_value1,
    output xlen_t    rob_value2,
    output logic     commit_valid,
    output commit_t  commit,
    output rob_tag_t commit_tag
);

    logic [ROB_DEPTH-1:0] done;
    logic [ROB_DEPTH-1:0] wr_q;
    arch_reg_t            rd_q  [ROB_DEPTH];
    xlen_t                val_q [ROB_DEPTH];
    rob_tag_t             head;
    rob_tag_t             tail;
    logic [TAG_W:0]       count;

    assign full      = (count == ROB_DEPTH);
    assign alloc_tag = tail;

    assign rob_done1  = done[query_tag1];
    assign rob_done2  = done[query_tag2];
    assign rob_value1 = val_q[query_tag1];
    assign rob_value2 = val_q[query_tag2];

    assign commit_valid = (count != '0) && done[head];
    assign commit_tag   = head;
    assign commit       = '{wr_en: wr_q[head], rd: rd_q[head], value: val_q[head]};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            done  <= '0;
        end else begin
            if (cdb.valid)
                done[cdb.tag] <= 1'b1;
            if (dispatch) begin
                done[tail] <= (uop.fu == FU_NONE);  // nothing to execute
                tail       <= tail + 1'b1;
            end
            if (commit_valid)
                head <= head + 1'b1;
            case ({dispatch, commit_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch) begin
            rd_q[tail] <= uop.rd;
            wr_q[tail] <= uop.wr_en;
        end
        // unsupported ops retire with zero
        if (dispatch && uop.fu == FU_NONE)
            val_q[tail] <= '0;
        if (cdb.valid)
            val_q[cdb.tag] <= cdb.value;
    end

endmodule

`default_nettype wire

// ==== hw/ooo_core.sv ====
`default_nettype none
`timescale 1ns/1ps

module ooo_core
    import ooo_pkg::*;
#(
    parameter int ALU_RS_DEPTH = 4,
    parameter int MUL_RS_DEPTH = 2
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    inst_valid,
    input  xlen_t   inst,
    output logic    issue_ready,
    output logic    commit_valid,
    output commit_t commit
);

    uop_t      uop;
    logic      dispatch;
    logic      rob_full;
    logic      alu_rs_full;
    logic      mul_rs_full;
    logic      alu_load;
    logic      mul_load;
    rob_tag_t  alloc_tag;
    rob_tag_t  query_tag1;
    rob_tag_t  query_tag2;
    rob_tag_t  commit_tag;
    logic      rob_done1;
    logic      rob_done2;
    xlen_t     rob_value1;
    xlen_t     rob_value2;
    rs_entry_t entry;
    rs_entry_t alu_req;
    rs_entry_t mul_req;
    logic      alu_send;
    logic      mul_send;
    logic      alu_ready;
    logic      mul_busy;
    cdb_t      cdb_alu;
    cdb_t      cdb;

    assign alu_load = dispatch && (uop.fu == FU_ALU);
    assign mul_load = dispatch && (uop.fu == FU_MUL);

    issue_decoder u_issue_decoder (
        .inst_valid  (inst_valid),
        .inst        (inst),
        .rob_full    (rob_full),
        .alu_rs_full (alu_rs_full),
        .mul_rs_full (mul_rs_full),
        .issue_ready (issue_ready),
        .dispatch    (dispatch),
        .uop         (uop)
    );

    rename_table u_rename_table (
        .clk          (clk),
        .rst_n        (rst_n),
        .dispatch     (dispatch),
        .uop          (uop),
        .alloc_tag    (alloc_tag),
        .rob_done1    (rob_done1),
        .rob_done2    (rob_done2),
        .rob_value1   (rob_value1),
        .rob_value2   (rob_value2),
        .cdb          (cdb),
        .commit_valid (commit_valid),
        .commit       (commit),
        .commit_tag   (commit_tag),
        .query_tag1   (query_tag1),
        .query_tag2   (query_tag2),
        .entry        (entry)
    );

    reservation_station #(.DEPTH(ALU_RS_DEPTH)) u_alu_rs (
        .clk        (clk),
        .rst_n      (rst_n),
        .load       (alu_load),
        .entry      (entry),
        .cdb        (cdb),
        .unit_ready (alu_ready),
        .full       (alu_rs_full),
        .send       (alu_send),
        .req        (alu_req)
    );

    // multiplier takes one op every cycle
    reservation_station #(.DEPTH(MUL_RS_DEPTH)) u_mul_rs (
        .clk        (clk),
        .rst_n      (rst_n),
        .load       (mul_load),
        .entry      (entry),
        .cdb        (cdb),
        .unit_ready (1'b1),
        .full       (mul_rs_full),
        .send       (mul_send),
        .req        (mul_req)
    );

    alu_unit u_alu_unit (
        .clk      (clk),
        .rst_n    (rst_n),
        .send     (alu_send),
        .req      (alu_req),
        .mul_busy (mul_busy),
        .ready    (alu_ready),
        .cdb_alu  (cdb_alu)
    );

    multiplier u_multiplier (
        .clk        (clk),
        .rst_n      (rst_n),
        .send       (mul_send),
        .req        (mul_req),
        .alu_result (cdb_alu),
        .mul_busy   (mul_busy),
        .cdb        (cdb)
    );

    reorder_buffer u_reorder_buffer (
        .clk          (clk),
        .rst_n        (rst_n),
        .dispatch     (dispatch),
        .uop          (uop),
        .cdb          (cdb),
        .query_tag1   (query_tag1),
        .query_tag2   (query_tag2),
        .full         (rob_full),
        .alloc_tag    (alloc_tag),
        .rob_done1    (rob_done1),
        .rob_done2    (rob_done2),
        .rob_value1   (rob_value1),
        .rob_value2   (rob_value2),
        .commit_valid (commit_valid),
        .commit       (commit),
        .commit_tag   (commit_tag)
    );

endmodule

`default_nettype wire

// ==== bench/tb_ooo_core.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_ooo_core
    import ooo_pkg::*;
();

    localparam int TIMEOUT = 200;   // cycles per wait

    logic        clk;
    logic        rst_n;
    logic        inst_valid;
    xlen_t       inst;
    logic        issue_ready;
    logic        commit_valid;
    commit_t     commit;

    xlen_t       model_regs [32];
    commit_t     exp_q [$];
    commit_t     exp_head;
    string       test_name;
    int          issued_count;
    int          commit_count;
    logic        ready_min;     // lowest issue_ready seen while stalled
    int          seed;

    ooo_core #(
        .ALU_RS_DEPTH (4),
        .MUL_RS_DEPTH (2)
    ) u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .issue_ready  (issue_ready),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run();
        $display("Test failures found");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_commit(input string name, input commit_t exp, input commit_t act);
        if (act !== exp) begin
            $display("error: %s expected wr=%0b rd=%0d val=%h, actual wr=%0b rd=%0d val=%h",
                     name, exp.wr_en, exp.rd, exp.value, act.wr_en, act.rd, act.value);
            abort_run();
        end
    endtask

    task automatic check_ready(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("error: %s expected issue_ready=%0b, actual %0b", name, exp, act);
            abort_run();
        end
    endtask

    // RV32I register and immediate ops
    function automatic xlen_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input xlen_t a, input xlen_t b);
        logic signed [31:0] sa;
        sa = a;
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101: begin
                if (alt)
                    return sa >>> b[4:0];
                else
                    return a >> b[4:0];
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic xlen_t mul_ref(input logic [1:0] f3, input xlen_t a, input xlen_t b);
        logic [63:0] ea;
        logic [63:0] eb;
        logic [63:0] p;
        ea = (f3 == 2'b01 || f3 == 2'b10) ? {{32{a[31]}}, a} : {32'b0, a};
        eb = (f3 == 2'b01) ? {{32{b[31]}}, b} : {32'b0, b};
        p  = ea * eb;   // mod 2^64 keeps the signed forms exact
        return (f3 == 2'b00) ? p[31:0] : p[63:32];
    endfunction

    function automatic arch_reg_t pick_reg();
        return arch_reg_t'(1 + $urandom % 31);
    endfunction

    task automatic send_word(input xlen_t word, input commit_t exp);
        int waited;
        waited     = 0;
        inst_valid = 1'b1;
        inst       = word;
        @(negedge clk);
        while (!issue_ready) begin
            ready_min = 1'b0;
            waited++;
            if (waited > TIMEOUT) begin
                $display("issue_ready stayed low too long in %s", test_name);
                abort_run();
            end
            @(negedge clk);
        end
        @(posedge clk);     // accepted on this edge
        exp_q.push_back(exp);
        issued_count++;
        #1;
        inst_valid = 1'b0;
    endtask

    task automatic issue_imm(input logic [2:0] f3, input arch_reg_t rd, input arch_reg_t rs1,
                             input logic [11:0] imm);
        commit_t exp;
        exp.wr_en = (rd != '0);
        exp.rd    = rd;
        exp.value = alu_ref(f3, (f3 == 3'b101) && imm[10], model_regs[rs1],
                            {{20{imm[11]}}, imm});
        if (rd != '0)
            model_regs[rd] = exp.value;
        send_word({imm, rs1, f3, rd, OPC_OP_IMM}, exp);
    endtask

    task automatic issue_reg(input logic [6:0] f7, input logic [2:0] f3, input arch_reg_t rd,
                             input arch_reg_t rs1, input arch_reg_t rs2);
        commit_t exp;
        exp.wr_en = (rd != '0);
        exp.rd    = rd;
        if (f7 == FUNCT7_MULDIV)
            exp.value = mul_ref(f3[1:0], model_regs[rs1], model_regs[rs2]);
        else
            exp.value = alu_ref(f3, f7[5], model_regs[rs1], model_regs[rs2]);
        if (rd != '0)
            model_regs[rd] = exp.value;
        send_word({f7, rs2, rs1, f3, rd, OPC_OP}, exp);
    endtask

    // retires without a register write
    task automatic issue_unsupported(input xlen_t word);
        commit_t exp;
        exp = '{wr_en: 1'b0, rd: word[11:7], value: '0};
        send_word(word, exp);
    endtask

    task automatic load_random(input arch_reg_t rd);
        issue_imm(3'b000, rd, 5'd0, 12'($urandom));
        issue_imm(3'b001, rd, rd, {7'b0, 5'($urandom)});
        issue_imm(3'b100, rd, rd, 12'($urandom));
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            waited++;
            if (waited > TIMEOUT) begin
                $display("%0d commits never arrived in %s", exp_q.size(), test_name);
                abort_run();
            end
            @(posedge clk);
            #1;
        end
    endtask

    task automatic run_imm_ops();
        logic [2:0]  f3;
        logic [11:0] imm;
        test_name = "imm_ops";
        for (int r = 1; r <= 8; r++)
            issue_imm(3'b000, arch_reg_t'(r), 5'd0, 12'($urandom));
        for (int n = 0; n < 24; n++) begin
            f3  = 3'($urandom);
            imm = 12'($urandom);
            if (f3 == 3'b001)
                imm = {7'b0, imm[4:0]};
            else if (f3 == 3'b101)
                imm = {1'b0, imm[10], 5'b0, imm[4:0]};  // srli or srai
            issue_imm(f3, pick_reg(), arch_reg_t'($urandom), imm);
        end
        drain();
    endtask

    task automatic run_reg_chain();
        arch_reg_t  prev;
        arch_reg_t  rd;
        logic [2:0] f3;
        logic       alt;
        test_name = "reg_chain";
        prev      = pick_reg();
        for (int n = 0; n < 16; n++) begin
            f3  = 3'($urandom);
            alt = (f3 == 3'b000 || f3 == 3'b101) ? 1'($urandom) : 1'b0;
            rd  = pick_reg();
            issue_reg({1'b0, alt, 5'b0}, f3, rd, prev, arch_reg_t'($urandom));
            prev = rd;
        end
        drain();
        // everything committed, sources from the register file
        for (int n = 0; n < 6; n++)
            issue_reg(7'b0, 3'b000, pick_reg(), pick_reg(), pick_reg());
        drain();
    endtask

    task automatic run_multiplies();
        test_name = "multiplies";
        issue_imm(3'b000, 5'd1, 5'd0, 12'd1);
        issue_imm(3'b001, 5'd1, 5'd1, 12'd31);     // 0x80000000
        issue_imm(3'b000, 5'd2, 5'd0, 12'hfff);    // -1
        issue_imm(3'b101, 5'd3, 5'd2, 12'd1);      // 0x7fffffff
        load_random(5'd4);
        load_random(5'd5);
        for (int v = 0; v < 4; v++)
            for (int s = 1; s <= 5; s++)
                for (int t = 0; t <= 5; t++)
                    issue_reg(FUNCT7_MULDIV, 3'(v), arch_reg_t'(6 + $urandom % 26),
                              arch_reg_t'(s), arch_reg_t'(t));
        drain();
    endtask

    task automatic run_out_of_order();
        test_name = "out_of_order";
        issue_reg(FUNCT7_MULDIV, 3'b000, 5'd10, 5'd4, 5'd5);
        for (int n = 11; n <= 16; n++)
            issue_imm(3'b000, arch_reg_t'(n), arch_reg_t'(1 + $urandom % 5), 12'($urandom));
        issue_reg(7'b0, 3'b000, 5'd17, 5'd11, 5'd12);  // done but not yet retired
        issue_reg(FUNCT7_MULDIV, 3'b011, 5'd18, 5'd10, 5'd17);
        drain();
    endtask

    task automatic run_back_pressure();
        test_name = "back_pressure";
        ready_min = 1'b1;
        issue_reg(FUNCT7_MULDIV, 3'b000, 5'd20, 5'd4, 5'd5);
        issue_reg(FUNCT7_MULDIV, 3'b001, 5'd21, 5'd20, 5'd5);
        issue_reg(FUNCT7_MULDIV, 3'b011, 5'd22, 5'd21, 5'd4);
        // these finish early and pile up behind the chain until the buffer is full
        for (int n = 23; n <= 30; n++)
            issue_imm(3'b000, arch_reg_t'(n), 5'd20, 12'($urandom));
        check_ready("back_pressure", 1'b0, ready_min);
        drain();
        check_ready("back_pressure drained", 1'b1, issue_ready);
    endtask

    task automatic run_x0_unsupported();
        test_name = "x0_unsupported";
        issue_imm(3'b000, 5'd0, 5'd5, 12'h123);
        issue_reg(7'b0, 3'b000, 5'd0, 5'd4, 5'd5);
        issue_unsupported({20'h12345, 5'd6, 7'b0110111});                       // lui
        issue_unsupported({FUNCT7_MULDIV, 5'd5, 5'd4, 3'b100, 5'd7, OPC_OP});  // div
        issue_reg(7'b0, 3'b000, 5'd8, 5'd0, 5'd0);
        issue_imm(3'b000, 5'd9, 5'd0, 12'h7ff);
        issue_reg(7'b0, 3'b110, 5'd10, 5'd6, 5'd7);
        drain();
    endtask

    always @(negedge clk) begin
        if (rst_n && commit_valid) begin
            if (exp_q.size() == 0) begin
                $display("commit seen with no instruction outstanding in %s", test_name);
                abort_run();
            end else begin
                exp_head = exp_q.pop_front();
                commit_count++;
                check_commit(test_name, exp_head, commit);
            end
        end
    end

    initial begin
        seed         = 20689;
        void'($urandom(seed));
        rst_n        = 1'b0;
        inst_valid   = 1'b0;
        inst         = '0;
        issued_count = 0;
        commit_count = 0;
        ready_min    = 1'b1;
        test_name    = "reset";
        for (int r = 0; r < 32; r++)
            model_regs[r] = '0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_ready("reset", 1'b1, issue_ready);
        if (commit_valid !== 1'b0) begin
            $display("commit_valid is not low after reset");
            abort_run();
        end
        run_imm_ops();
        run_reg_chain();
        run_multiplies();
        run_out_of_order();
        run_back_pressure();
        run_x0_unsupported();
        if (issued_count == commit_count && exp_q.size() == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("%0d instructions issued but %0d commits seen", issued_count, commit_count);
            abort_run();
        end
    end

endmodule

`default_nettype wire

// ==== ooo_core.f ====
hw/ooo_pkg.sv
hw/issue_decoder.sv
hw/rename_table.sv
hw/reservation_station.sv
hw/alu_unit.sv
hw/multiplier.sv
hw/reorder_buffer.sv
hw/ooo_core.sv
bench/tb_ooo_core.sv

// ==== Bender.yml ====
package:
  name: ooo_core

sources:
  - files:
      - hw/ooo_pkg.sv
      - hw/issue_decoder.sv
      - hw/rename_table.sv
      - hw/reservation_station.sv
      - hw/alu_unit.sv
      - hw/multiplier.sv
      - hw/reorder_buffer.sv
      - hw/ooo_core.sv
  - target: simulation
    files:
      - bench/tb_ooo_core.sv
